/* addressPath.sv */
`timescale 1ns/1ns
`default_nettype none

module addressPath
  import archPkg::*;
(
  input  wire logic        clk,
  input  wire logic        arstN,
  input  wire logic [31:0] instrD,
  input  wire logic [1:0]  regSrcD,
  input  wire logic [3:0]  regFileRzD,
  input  wire logic [4:0]  cpsrMode,
  output physSel_t         ra1D,
  output physSel_t         ra2D,
  output physSel_t         wa3W,
  hazardIf.path            hz
);

  modeOneHot_t modeD;
  logic [3:0]  ra1RnD;
  logic [3:0]  ra1NumD;
  logic [3:0]  ra2NumD;
  logic [3:0]  wa3NumD;
  physSel_t    wa3D;
  physSel_t    wa3E;
  physSel_t    ra1E;
  physSel_t    ra2E;
  physSel_t    wa3M;

  // ============================
  // Decode stage
  // ============================

  // Mode field to one-hot, anything unknown runs as user
  always_comb begin
    modeD = '0;
    case (cpsrMode)
      ModeFiq: modeD[ModeBitFiq] = 1'b1;
      ModeIrq: modeD[ModeBitIrq] = 1'b1;
      ModeSvc: modeD[ModeBitSvc] = 1'b1;
      ModeAbt: modeD[ModeBitAbt] = 1'b1;
      ModeUnd: modeD[ModeBitUnd] = 1'b1;
      ModeUsr, ModeSys: modeD[ModeBitUsr] = 1'b1;
      default: modeD[ModeBitUsr] = 1'b1;
    endcase
  end

  // Port 1 takes Rn, PC, or Rs for register-shifted operands
  assign ra1RnD  = regSrcD[0] ? RegPc : instrD[19:16];
  assign ra1NumD = (regFileRzD[2] & regFileRzD[3]) ? instrD[11:8] : ra1RnD;
  // Port 2 takes Rm, or Rd for stores
  assign ra2NumD = regSrcD[1] ? instrD[15:12] : instrD[3:0];
  assign wa3NumD = instrD[15:12];

  bankedRegDecode ra1Dec (.regNum(ra1NumD), .en(regFileRzD[0]), .mode(modeD), .physSel(ra1D));
  bankedRegDecode ra2Dec (.regNum(ra2NumD), .en(regFileRzD[1]), .mode(modeD), .physSel(ra2D));
  bankedRegDecode wa3Dec (.regNum(wa3NumD), .en(regFileRzD[2]), .mode(modeD), .physSel(wa3D));

  // ============================
  // Execute stage
  // ============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3E <= '0;
      ra1E <= '0;
      ra2E <= '0;
    end else if (!hz.stallE) begin
      wa3E <= wa3D;
      ra1E <= ra1D;
      ra2E <= ra2D;
    end
  end

  // Decode reads against the write in Execute
  assign hz.match1DE = |(wa3E & ra1D);
  assign hz.match2DE = |(wa3E & ra2D);

  // ============================
  // Memory stage
  // ============================

  // Match bits ride along with the writer into Memory
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3M        <= '0;
      hz.match1EM <= 1'b0;
      hz.match2EM <= 1'b0;
    end else if (hz.flushM) begin
      wa3M        <= '0;
      hz.match1EM <= 1'b0;
      hz.match2EM <= 1'b0;
    end else if (!hz.stallM) begin
      wa3M        <= wa3E;
      hz.match1EM <= hz.match1DE;
      hz.match2EM <= hz.match2DE;
    end
  end

  // ============================
  // Writeback stage
  // ============================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3W <= '0;
    end else if (hz.flushW) begin
      wa3W <= '0;
    end else if (!hz.stallW) begin
      wa3W <= wa3M;
    end
  end

  // Execute reads against the write in Writeback
  assign hz.match1EW = |(wa3W & ra1E);
  assign hz.match2EW = |(wa3W & ra2E);

  // Mode decode never lands on two banks at once
  modeOneHotChk: assert property (@(posedge clk) disable iff (!arstN) $onehot0(modeD))
    else $error("addressPath: mode one-hot %b", modeD);

endmodule

`default_nettype wire

/* archPkg.sv */
`default_nettype none

package archPkg;

  // ============================
  // Physical register file layout
  // ============================
  localparam int NumPhysRegs = 31;

  // One hot line, bit n selects physical register n
  typedef logic [NumPhysRegs-1:0] physSel_t;

  // Mode one-hot, user/sys in the top bit down to undef in bit 0
  typedef logic [5:0] modeOneHot_t;

  localparam int ModeBitUsr = 5;
  localparam int ModeBitFiq = 4;
  localparam int ModeBitIrq = 3;
  localparam int ModeBitSvc = 2;
  localparam int ModeBitAbt = 1;
  localparam int ModeBitUnd = 0;

  // CPSR mode field codes
  localparam logic [4:0] ModeUsr = 5'b10000;
  localparam logic [4:0] ModeFiq = 5'b10001;
  localparam logic [4:0] ModeIrq = 5'b10010;
  localparam logic [4:0] ModeSvc = 5'b10011;
  localparam logic [4:0] ModeAbt = 5'b10111;
  localparam logic [4:0] ModeUnd = 5'b11011;
  localparam logic [4:0] ModeSys = 5'b11111;

  localparam logic [3:0] RegPc = 4'd15;

  // Banked copies above the shared r0..r15
  // r0-r7 and r15 shared by all modes
  // r8-r12 go to FiqBankBase+0..4 in fiq only
  // r13/r14 go to bank base +0/+1, fiq uses FiqBankBase+5/+6
  // Unknown mode codes act as user
  localparam int FiqBankBase = 16;
  localparam int IrqBankBase = 23;
  localparam int SvcBankBase = 25;
  localparam int AbtBankBase = 27;
  localparam int UndBankBase = 29;

endpackage

`default_nettype wire

/* bankedRegDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module bankedRegDecode
  import archPkg::*;
(
  input  wire logic [3:0]  regNum,
  input  wire logic        en,
  input  wire modeOneHot_t mode,
  output physSel_t         physSel
);

  logic [4:0] physIdx;
  logic [4:0] bankOfs;

  // r14 sits one above r13 in each bank
  assign bankOfs = (regNum == 4'd14) ? 5'd1 : 5'd0;

  always_comb begin
    // Shared register by default
    physIdx = {1'b0, regNum};
    if (mode[ModeBitFiq] && regNum >= 4'd8 && regNum <= 4'd14) begin
      // Fiq banks r8 through r14 as one block
      physIdx = 5'(FiqBankBase) + 5'(regNum - 4'd8);
    end else if (regNum == 4'd13 || regNum == 4'd14) begin
      // SP and LR banked per privileged mode
      if (mode[ModeBitIrq]) begin
        physIdx = 5'(IrqBankBase) + bankOfs;
      end else if (mode[ModeBitSvc]) begin
        physIdx = 5'(SvcBankBase) + bankOfs;
      end else if (mode[ModeBitAbt]) begin
        physIdx = 5'(AbtBankBase) + bankOfs;
      end else if (mode[ModeBitUnd]) begin
        physIdx = 5'(UndBankBase) + bankOfs;
      end
    end
  end

  // Disabled port drives no line at all
  assign physSel = en ? (physSel_t'(1'b1) << physIdx) : '0;

  // Exactly one line when enabled
  always_comb begin
    assert final ($onehot0(physSel) && (en == (|physSel)))
      else $error("bankedRegDecode: bad line %h for r%0d", physSel, regNum);
  end

endmodule

`default_nettype wire

/* build.f */
archPkg.sv
pipePkg.sv
hazardIf.sv
bankedRegDecode.sv
addressPath.sv
memWaitTimer.sv
hazardUnit.sv
regAddrTop.sv
regAddrTb.sv

/* hazardIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface hazardIf;

  // Overlap of a read address with a later-stage write address
  logic match1DE;
  logic match2DE;
  logic match1EM;
  logic match2EM;
  logic match1EW;
  logic match2EW;

  // Stage register holds and clears
  logic stallE;
  logic stallM;
  logic stallW;
  logic flushM;
  logic flushW;

  // Address path side
  modport path (
    output match1DE, match2DE, match1EM, match2EM, match1EW, match2EW,
    input  stallE, stallM, stallW, flushM, flushW
  );

  // Hazard FSM side
  modport hazard (
    input  match1DE, match2DE, match1EM, match2EM, match1EW, match2EW,
    output stallE, stallM, stallW, flushM, flushW
  );

endinterface

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit
  import pipePkg::*;
(
  input  wire logic clk,
  input  wire logic arstN,
  input  wire logic loadE,
  hazardIf.hazard   hz,
  input  wire logic done,
  output logic      start,
  output logic      stallD,
  output fwdSel_t   fwdA,
  output fwdSel_t   fwdB
);

  hazState_t state;
  hazState_t stateNext;
  logic      loadM;
  logic      bubbleR;
  logic      memStall;
  logic      useStall;

  // ============================
  // Hazard FSM
  // ============================
  always_comb begin
    stateNext = state;
    start     = 1'b0;
    memStall  = 1'b0;
    useStall  = 1'b0;
    case (state)
      HazRun: begin
        // Load in Memory beats a pending load-use bubble
        if (loadM) begin
          start     = 1'b1;
          memStall  = 1'b1;
          stateNext = HazMemWait;
        end else if (loadE && (hz.match1DE || hz.match2DE) && !bubbleR) begin
          // One bubble only, the load moves on next cycle
          useStall = 1'b1;
        end
      end
      HazMemWait: begin
        // Freeze until the timer's final cycle
        if (done) begin
          stateNext = HazRun;
        end else begin
          memStall = 1'b1;
        end
      end
      default: stateNext = HazRun;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= HazRun;
      bubbleR <= 1'b0;
    end else begin
      state   <= stateNext;
      bubbleR <= useStall;
    end
  end

  // Load flag follows the instruction into Memory
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      loadM <= 1'b0;
    end else if (hz.flushM) begin
      loadM <= 1'b0;
    end else if (!hz.stallM) begin
      loadM <= loadE;
    end
  end

  // Stage controls
  assign stallD    = memStall | useStall;
  assign hz.stallE = memStall | useStall;
  assign hz.stallM = memStall;
  assign hz.stallW = memStall;
  assign hz.flushW = memStall;
  assign hz.flushM = useStall;

  // Newest result wins, Memory before Writeback
  assign fwdA = hz.match1EM ? FwdMem : (hz.match1EW ? FwdWb : FwdReg);
  assign fwdB = hz.match2EM ? FwdMem : (hz.match2EW ? FwdWb : FwdReg);

  // A bubble into a frozen Memory stage would lose the load
  flushStallChk: assert property (@(posedge clk) disable iff (!arstN) !(hz.flushM && hz.stallM))
    else $error("hazardUnit: flushM with stallM");

endmodule

`default_nettype wire

/* memWaitTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module memWaitTimer
  import pipePkg::*;
(
  input  wire logic clk,
  input  wire logic arstN,
  input  wire logic start,
  output logic      done
);

  logic                  busy;
  logic [TimerWidth-1:0] count;

  // Load on start, count down to zero, then idle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      count <= TimerWidth'(MemWaitCycles - 1);
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // Last cycle of the wait
  assign done = busy && (count == '0);

  // Hazard FSM waits for done before the next load
  startIdleChk: assert property (@(posedge clk) disable iff (!arstN) start |-> (count == '0))
    else $error("memWaitTimer: start with count %0d", count);

endmodule

`default_nettype wire

/* pipePkg.sv */
`default_nettype none

package pipePkg;

  // ============================
  // Forwarding and hazard FSM
  // ============================

  // Operand source for the Execute stage
  typedef enum logic [1:0] {
    FwdReg = 2'b00,
    FwdWb  = 2'b01,
    FwdMem = 2'b10
  } fwdSel_t;

  typedef enum logic {
    HazRun     = 1'b0,
    HazMemWait = 1'b1
  } hazState_t;

  // Extra stall cycles while a load sits in Memory
  localparam int MemWaitCycles = 2;

  // Counter holds MemWaitCycles-1 at most, never narrower than one bit
  localparam int TimerWidth = (MemWaitCycles > 1) ? $clog2(MemWaitCycles) : 1;

endpackage

`default_nettype wire

/* regAddrTb.sv */
`timescale 1ns/1ns
`default_nettype none

module regAddrTb
  import archPkg::*;
  import pipePkg::*;
();

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [1:0]  regSrcD;
  logic [3:0]  regFileRzD;
  logic [4:0]  cpsrMode;
  logic        loadE;
  physSel_t    ra1D;
  physSel_t    ra2D;
  physSel_t    wa3W;
  logic        stallD;
  logic        stallE;
  logic        flushM;
  fwdSel_t     fwdA;
  fwdSel_t     fwdB;

  integer seed;
  int     errors;
  int     testsRun;
  int     testsFailed;

  regAddrTop dut_i (.*);

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // Reference model and helpers
  // ==============================

  // Banked register number to physical one-hot
  function automatic physSel_t modelLine(input logic [3:0] num, input logic [4:0] mode,
                                         input logic en);
    physSel_t line;
    int       idx;
    line = '0;
    idx  = num;
    if (mode == ModeFiq && num >= 4'd8 && num <= 4'd14) begin
      idx = FiqBankBase + num - 8;
    end else if (num == 4'd13 || num == 4'd14) begin
      // SP and LR per privileged mode, user/sys and unknown keep 13/14
      case (mode)
        ModeIrq: idx = IrqBankBase + num - 13;
        ModeSvc: idx = SvcBankBase + num - 13;
        ModeAbt: idx = AbtBankBase + num - 13;
        ModeUnd: idx = UndBankBase + num - 13;
        default: idx = num;
      endcase
    end
    if (en) line[idx] = 1'b1;
    return line;
  endfunction

  // Rn in 19:16, Rd in 15:12, Rs in 11:8, Rm in 3:0
  function automatic logic [31:0] makeInstr(input logic [3:0] rd, input logic [3:0] rn,
                                            input logic [3:0] rm, input logic [3:0] rs);
    return {12'h000, rn, rd, rs, 4'h0, rm};
  endfunction

  // Next instruction into Decode
  task automatic issue(input logic [31:0] instr, input logic [1:0] src,
                       input logic [3:0] rz, input logic [4:0] mode);
    @(posedge clk);
    instrD     <= instr;
    regSrcD    <= src;
    regFileRzD <= rz;
    cpsrMode   <= mode;
  endtask

  task automatic nop();
    issue(32'h0, 2'b00, 4'b0000, ModeUsr);
  endtask

  // Empty all stages
  task automatic drainPipe();
    repeat (4) nop();
  endtask

  task automatic expectVal(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testsRun++;
    if (errors == errorsBefore) begin
      $display("Test %s: ok", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errors - errorsBefore);
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================

  task automatic testBankedDecode();
    logic [4:0] modes [8];
    logic [3:0] rn;
    int         start;
    start = errors;
    // Last entry is no valid mode code
    modes = '{ModeUsr, ModeFiq, ModeIrq, ModeSvc, ModeAbt, ModeUnd, ModeSys, 5'b00110};
    foreach (modes[m]) begin
      // Rm sweeps all numbers, Rn random
      for (int i = 0; i < 16; i++) begin
        rn = 4'($random(seed));
        issue(makeInstr(4'd0, rn, 4'(i), 4'd0), 2'b00, 4'b0011, modes[m]);
        @(negedge clk);
        expectVal("ra1D", ra1D, modelLine(rn, modes[m], 1'b1));
        expectVal("ra2D", ra2D, modelLine(4'(i), modes[m], 1'b1));
      end
    end
    reportTest("banked decode", start);
  endtask

  task automatic testSourceSelect();
    logic [31:0] instr;
    logic [3:0]  rn;
    logic [3:0]  rm;
    int          start;
    start = errors;
    // Low registers stay clear of PC, Rs and Rd
    rn    = 4'($random(seed)) & 4'h7;
    rm    = 4'($random(seed)) & 4'h7;
    // Rd r14 and Rs r13 show the svc bank
    instr = makeInstr(4'd14, rn, rm, 4'd13);
    issue(instr, 2'b01, 4'b0011, ModeSvc);
    @(negedge clk);
    expectVal("ra1D pc", ra1D, modelLine(RegPc, ModeSvc, 1'b1));
    expectVal("ra2D rm", ra2D, modelLine(rm, ModeSvc, 1'b1));
    issue(instr, 2'b10, 4'b1111, ModeSvc);
    @(negedge clk);
    expectVal("ra1D rs", ra1D, modelLine(4'd13, ModeSvc, 1'b1));
    expectVal("ra2D rd", ra2D, modelLine(4'd14, ModeSvc, 1'b1));
    issue(instr, 2'b00, 4'b0000, ModeSvc);
    @(negedge clk);
    expectVal("ra1D off", ra1D, '0);
    expectVal("ra2D off", ra2D, '0);
    drainPipe();
    reportTest("source select", start);
  endtask

  task automatic testWritePipe();
    logic [3:0] rd;
    int         start;
    start = errors;
    drainPipe();
    rd = 4'($random(seed));
    issue(makeInstr(rd, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeIrq);
    nop();
    nop();
    @(negedge clk);
    expectVal("wa3W early", wa3W, '0);
    nop();
    @(negedge clk);
    expectVal("wa3W", wa3W, modelLine(rd, ModeIrq, 1'b1));
    // Disabled write carries nothing
    issue(makeInstr(rd, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0000, ModeIrq);
    repeat (3) nop();
    @(negedge clk);
    expectVal("wa3W off", wa3W, '0);
    reportTest("write pipeline", start);
  endtask

  task automatic testForwarding();
    int start;
    start = errors;
    drainPipe();
    // Back to back, result still in Memory
    issue(makeInstr(4'd6, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd6, 4'd0, 4'd0), 2'b00, 4'b0001, ModeUsr);
    nop();
    @(negedge clk);
    expectVal("fwdA mem", fwdA, FwdMem);
    expectVal("fwdB reg", fwdB, FwdReg);
    drainPipe();
    // One unrelated writer between, result in Writeback
    issue(makeInstr(4'd6, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd9, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd0, 4'd6, 4'd0), 2'b00, 4'b0010, ModeUsr);
    nop();
    @(negedge clk);
    expectVal("fwdB wb", fwdB, FwdWb);
    drainPipe();
    // Two writers of r6, newest in Memory
    issue(makeInstr(4'd6, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd6, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd6, 4'd0, 4'd0), 2'b00, 4'b0001, ModeUsr);
    nop();
    @(negedge clk);
    expectVal("fwdA both", fwdA, FwdMem);
    drainPipe();
    issue(makeInstr(4'd9, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0001, ModeUsr);
    nop();
    @(negedge clk);
    expectVal("fwdA r0", fwdA, FwdReg);
    reportTest("forwarding", start);
  endtask

  task automatic testLoadStall();
    int   start;
    int   cycles;
    int   waited;
    logic ended;
    start = errors;
    drainPipe();
    issue(makeInstr(4'd4, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd4, 4'd0, 4'd0), 2'b00, 4'b0001, ModeUsr);
    // Load now in Execute, its reader in Decode
    loadE <= 1'b1;
    @(negedge clk);
    expectVal("stallD bubble", stallD, 1'b1);
    expectVal("stallE bubble", stallE, 1'b1);
    expectVal("flushM bubble", flushM, 1'b1);
    @(negedge clk);
    expectVal("stallD after bubble", stallD, 1'b0);
    expectVal("flushM after bubble", flushM, 1'b0);
    // Load moves to Memory, reader to Execute
    nop();
    loadE <= 1'b0;
    cycles = 0;
    waited = 0;
    ended  = 1'b0;
    while (!ended && waited < 20) begin
      @(negedge clk);
      waited++;
      if (stallE) begin
        cycles++;
      end else if (cycles > 0) begin
        ended = 1'b1;
      end
    end
    if (!ended) begin
      $display("Timeout: stallE did not rise and fall within %0d cycles of the load", waited);
      errors++;
    end
    expectVal("memory wait cycles", cycles, MemWaitCycles);
    expectVal("stallD after wait", stallD, 1'b0);
    reportTest("load stalls", start);
  endtask

  task automatic testReset();
    int start;
    start = errors;
    drainPipe();
    issue(makeInstr(4'd7, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    nop();
    // Load of r5, then its reader
    issue(makeInstr(4'd5, 4'd0, 4'd0, 4'd0), 2'b00, 4'b0100, ModeUsr);
    issue(makeInstr(4'd0, 4'd5, 4'd0, 4'd0), 2'b00, 4'b0001, ModeUsr);
    loadE <= 1'b1;
    // r7 in Writeback and a load-use bubble due as reset hits
    arstN <= 1'b0;
    @(negedge clk);
    expectVal("wa3W in reset", wa3W, '0);
    expectVal("stallD in reset", stallD, 1'b0);
    expectVal("stallE in reset", stallE, 1'b0);
    expectVal("flushM in reset", flushM, 1'b0);
    @(posedge clk);
    arstN <= 1'b1;
    loadE <= 1'b0;
    nop();
    nop();
    @(negedge clk);
    expectVal("wa3W after reset", wa3W, '0);
    expectVal("stallE after reset", stallE, 1'b0);
    reportTest("reset", start);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    seed        = 32'h9b4e;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    arstN       = 1'b0;
    instrD      = '0;
    regSrcD     = '0;
    regFileRzD  = '0;
    cpsrMode    = ModeUsr;
    loadE       = 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    testBankedDecode();
    testSourceSelect();
    testWritePipe();
    testForwarding();
    testLoadStall();
    testReset();
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* regAddrTop.sv */
`timescale 1ns/1ns
`default_nettype none

module regAddrTop
  import archPkg::*;
  import pipePkg::*;
(
  input  wire logic        clk,
  input  wire logic        arstN,
  input  wire logic [31:0] instrD,
  input  wire logic [1:0]  regSrcD,
  input  wire logic [3:0]  regFileRzD,
  input  wire logic [4:0]  cpsrMode,
  input  wire logic        loadE,
  output physSel_t         ra1D,
  output physSel_t         ra2D,
  output physSel_t         wa3W,
  output logic             stallD,
  output logic             stallE,
  output logic             flushM,
  output fwdSel_t          fwdA,
  output fwdSel_t          fwdB
);

  // Match and control bundle between path and FSM
  hazardIf hz ();

  logic timerStart;
  logic timerDone;

  addressPath pathInst (
    .clk        (clk),
    .arstN      (arstN),
    .instrD     (instrD),
    .regSrcD    (regSrcD),
    .regFileRzD (regFileRzD),
    .cpsrMode   (cpsrMode),
    .ra1D       (ra1D),
    .ra2D       (ra2D),
    .wa3W       (wa3W),
    .hz         (hz.path)
  );

  hazardUnit hazInst (
    .clk    (clk),
    .arstN  (arstN),
    .loadE  (loadE),
    .hz     (hz.hazard),
    .done   (timerDone),
    .start  (timerStart),
    .stallD (stallD),
    .fwdA   (fwdA),
    .fwdB   (fwdB)
  );

  memWaitTimer timerInst (
    .clk   (clk),
    .arstN (arstN),
    .start (timerStart),
    .done  (timerDone)
  );

  // Controls visible to the surrounding pipeline
  assign stallE = hz.stallE;
  assign flushM = hz.flushM;

endmodule

`default_nettype wire
